//--- filelist.f
common/pa_pkg.sv
design/rand_mem.sv
pa/pa_engine.sv
link/a_packet.sv
link/link_model.sv
link/b_unpacket.sv
design/pa_top.sv
bench/pa_tb_chk.sv
bench/pa_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module pa_tb -f filelist.f -o pa_sim

out=$(./obj_dir/pa_sim) || true
echo "$out"

if echo "$out" | grep -qx "Test passed"; then
    exit 0
fi
exit 1

//--- bench/pa_tb.sv
`timescale 1ns/1ps

module pa_tb;

    localparam int num_scen    = 5;
    // reset, loads, debounce, message out and back, longest hash, slack
    localparam int scen_cycles = 4 + pa_pkg::key_mem_words + pa_pkg::rand_words
                               + pa_pkg::start_fire_cnt + 2 * pa_pkg::msg_words
                               + pa_pkg::link_delay
                               + pa_pkg::max_secret_words * (pa_pkg::key_words + 1) + 32;
    localparam int watchdog_ns = num_scen * scen_cycles * 2 * 10;

    logic               clk = 1'b0;
    logic               rst_n;
    logic               start_switch;
    pa_pkg::len_t       secret_len;
    logic               key_half;
    pa_pkg::load_wr_t   load;
    pa_pkg::secret_wr_t alice_secret;
    pa_pkg::secret_wr_t bob_secret;
    logic               alice_finish;
    logic               alice_fail;
    logic               bob_finish;
    logic               bob_fail;

    pa_pkg::word_t key_arr   [pa_pkg::key_mem_words];
    pa_pkg::word_t rand_arr  [pa_pkg::rand_words];
    pa_pkg::word_t model     [pa_pkg::max_secret_words];   // expected secret words
    pa_pkg::word_t alice_got [pa_pkg::max_secret_words];   // what alice wrote this run
    logic [63:0]   rng;
    int            exp_len;
    logic          expect_fail;
    int            sw_cycles;       // edges with the switch high
    int            alice_wr_cnt;
    int            bob_wr_cnt;
    int            alice_err = 0;
    int            bob_err   = 0;
    int            seq_err   = 0;
    int            scen_done = 0;

    pa_top u_pa_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_switch (start_switch),
        .secret_len   (secret_len),
        .key_half     (key_half),
        .load         (load),
        .alice_secret (alice_secret),
        .bob_secret   (bob_secret),
        .alice_finish (alice_finish),
        .alice_fail   (alice_fail),
        .bob_finish   (bob_finish),
        .bob_fail     (bob_fail)
    );

    always #5 clk = ~clk;

    // scoreboard counters
    always @(posedge clk) begin
        if (!rst_n) begin
            sw_cycles    <= 0;
            alice_wr_cnt <= 0;
            bob_wr_cnt   <= 0;
            for (int i = 0; i < pa_pkg::max_secret_words; i++) begin
                alice_got[i] <= '0;
            end
        end else begin
            if (start_switch) begin
                sw_cycles <= sw_cycles + 1;
            end
            if (alice_secret.wr) begin
                alice_got[alice_secret.addr] <= alice_secret.data;
                alice_wr_cnt <= alice_wr_cnt + 1;
            end
            if (bob_secret.wr) begin
                bob_wr_cnt <= bob_wr_cnt + 1;
            end
        end
    end

    a_quiet_before_start: assert property (@(posedge clk) disable iff (!rst_n)
        sw_cycles < pa_pkg::start_fire_cnt |-> !(alice_secret.wr || bob_secret.wr ||
            alice_finish || alice_fail || bob_finish || bob_fail))
        else begin
            seq_err++;
            $display("[FAIL] %0t output activity before the start pulse", $time);
        end

    // in-order writes that each match the hash rule
    a_alice_word: assert property (@(posedge clk) disable iff (!rst_n)
        alice_secret.wr |-> alice_wr_cnt < exp_len && int'(alice_secret.addr) == alice_wr_cnt
            && alice_secret.data == model[alice_wr_cnt])
        else begin
            alice_err++;
            $display("[FAIL] %0t alice write %0d at addr %0d: got %h, expected %h", $time,
                     $sampled(alice_wr_cnt), $sampled(alice_secret.addr),
                     $sampled(alice_secret.data), model[$sampled(alice_wr_cnt)]);
        end

    a_bob_word: assert property (@(posedge clk) disable iff (!rst_n)
        bob_secret.wr |-> bob_wr_cnt < exp_len && int'(bob_secret.addr) == bob_wr_cnt
            && bob_secret.data == model[bob_wr_cnt])
        else begin
            bob_err++;
            $display("[FAIL] %0t bob write %0d at addr %0d: got %h, expected %h", $time,
                     $sampled(bob_wr_cnt), $sampled(bob_secret.addr),
                     $sampled(bob_secret.data), model[$sampled(bob_wr_cnt)]);
        end

    a_bob_vs_alice: assert property (@(posedge clk) disable iff (!rst_n)
        bob_secret.wr |-> bob_secret.data == alice_got[bob_secret.addr])
        else begin
            bob_err++;
            $display("[FAIL] %0t bob word %0d differs from alice word", $time,
                     $sampled(bob_secret.addr));
        end

    a_alice_end: assert property (@(posedge clk) disable iff (!rst_n)
        (!alice_finish || (!expect_fail && alice_wr_cnt == exp_len)) &&
        (!alice_fail || expect_fail))
        else begin
            alice_err++;
            $display("[FAIL] %0t alice ended wrong: finish %0b fail %0b after %0d writes",
                     $time, $sampled(alice_finish), $sampled(alice_fail),
                     $sampled(alice_wr_cnt));
        end

    a_bob_end: assert property (@(posedge clk) disable iff (!rst_n)
        (!bob_finish || (!expect_fail && bob_wr_cnt == exp_len)) &&
        (!bob_fail || expect_fail))
        else begin
            bob_err++;
            $display("[FAIL] %0t bob ended wrong: finish %0b fail %0b after %0d writes",
                     $time, $sampled(bob_finish), $sampled(bob_fail), $sampled(bob_wr_cnt));
        end

    function automatic logic [63:0] xorshift64(input logic [63:0] s);
        logic [63:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 7);
        x = x ^ (x << 17);
        return x;
    endfunction

    task automatic draw_data();
        for (int a = 0; a < pa_pkg::key_mem_words; a++) begin
            rng = xorshift64(rng);
            key_arr[a] = rng;
        end
        for (int a = 0; a < pa_pkg::rand_words; a++) begin
            rng = xorshift64(rng);
            rand_arr[a] = rng;
        end
    endtask

    // word i = xor over k of key[k] and rand[i+k]
    task automatic compute_model(input logic half);
        pa_pkg::word_t acc;
        int            base;
        base = half ? pa_pkg::key_words : 0;
        for (int i = 0; i < pa_pkg::max_secret_words; i++) begin
            acc = '0;
            for (int k = 0; k < pa_pkg::key_words; k++) begin
                acc = acc ^ (key_arr[base + k] & rand_arr[i + k]);
            end
            model[i] = acc;
        end
    endtask

    task automatic load_memories();
        for (int a = 0; a < pa_pkg::key_mem_words; a++) begin
            @(negedge clk);
            load = '{wr: 1'b1, target: pa_pkg::tgt_key, addr: pa_pkg::key_addr_t'(a),
                     data: key_arr[a]};
        end
        for (int a = 0; a < pa_pkg::rand_words; a++) begin
            @(negedge clk);
            load = '{wr: 1'b1, target: pa_pkg::tgt_rand, addr: pa_pkg::key_addr_t'(a),
                     data: rand_arr[a]};
        end
        @(negedge clk);
        load = '0;
    endtask

    task automatic run_scenario(input int len, input logic half);
        @(negedge clk);
        rst_n        = 1'b0;
        start_switch = 1'b0;
        secret_len   = pa_pkg::len_t'(len);
        key_half     = half;
        expect_fail  = (len < 1 || len > pa_pkg::max_secret_words);
        exp_len      = expect_fail ? 0 : len;
        compute_model(half);
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        load_memories();
        @(negedge clk);
        start_switch = 1'b1;
        while (!((alice_finish || alice_fail) && (bob_finish || bob_fail))) begin
            @(negedge clk);
        end
        repeat (8) @(negedge clk);   // room for a stray late write
        start_switch = 1'b0;
        scen_done++;
    endtask

    initial begin
        #(watchdog_ns);
        $display("timeout: both sides had not ended after %0d ns", watchdog_ns);
        $display("Test failed");
        $finish;
    end

    initial begin
        int rand_len;
        int total;
        rst_n        = 1'b0;
        start_switch = 1'b0;
        secret_len   = '0;
        key_half     = 1'b0;
        load         = '0;
        exp_len      = 0;
        expect_fail  = 1'b0;
        rng          = 64'd11633;

        draw_data();
        rng = xorshift64(rng);
        rand_len = int'(rng[2:0]) + 1;                   // 1..8
        run_scenario(rand_len, 1'b0);
        run_scenario(rand_len, 1'b1);                    // same data with the upper key half
        draw_data();
        run_scenario(pa_pkg::max_secret_words, 1'b0);
        run_scenario(0, 1'b0);
        run_scenario(pa_pkg::max_secret_words + 1, 1'b0);

        total = alice_err + bob_err + seq_err;
        $display("summary: %0d scenarios, %0d alice errors, %0d bob errors, %0d sequence errors",
                 scen_done, alice_err, bob_err, seq_err);
        if (total == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- bench/pa_tb_chk.sv
`timescale 1ns/1ps

module pa_tb_chk (
    input logic               clk,
    input logic               rst_n,
    input logic               start_pa,
    input pa_pkg::secret_wr_t alice_secret,
    input pa_pkg::secret_wr_t bob_secret,
    input logic               alice_finish,
    input logic               alice_fail,
    input logic               bob_finish,
    input logic               bob_fail
);

    // start pulse never stretches
    a_start_single: assert property (@(posedge clk) disable iff (!rst_n)
        $past(start_pa) |-> !start_pa)
        else $error("start_pa held for more than one cycle");

    a_alice_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(alice_finish && alice_fail))
        else $error("alice finish and fail both high");

    a_bob_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(bob_finish && bob_fail))
        else $error("bob finish and fail both high");

    // terminal states are silent
    a_alice_quiet_end: assert property (@(posedge clk) disable iff (!rst_n)
        (alice_finish || alice_fail) |-> !alice_secret.wr)
        else $error("alice secret write after finish or fail");

    a_bob_quiet_end: assert property (@(posedge clk) disable iff (!rst_n)
        (bob_finish || bob_fail) |-> !bob_secret.wr)
        else $error("bob secret write after finish or fail");

endmodule

bind pa_top pa_tb_chk u_chk (
    .clk          (clk),
    .rst_n        (rst_n),
    .start_pa     (start_pa),
    .alice_secret (alice_secret),
    .bob_secret   (bob_secret),
    .alice_finish (alice_finish),
    .alice_fail   (alice_fail),
    .bob_finish   (bob_finish),
    .bob_fail     (bob_fail)
);

//--- design/pa_top.sv
`timescale 1ns/1ps

module pa_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start_switch,
    input  pa_pkg::len_t       secret_len,
    input  logic               key_half,        // selects key words 0..15 or 16..31
    input  pa_pkg::load_wr_t   load,
    output pa_pkg::secret_wr_t alice_secret,
    output pa_pkg::secret_wr_t bob_secret,
    output logic               alice_finish,
    output logic               alice_fail,
    output logic               bob_finish,
    output logic               bob_fail
);

    logic [7:0]         start_cnt;
    logic               start_pa;
    logic               load_ok;

    pa_pkg::word_t      key_mem [pa_pkg::key_mem_words];
    pa_pkg::word_t      alice_key_q;
    pa_pkg::word_t      bob_key_q;
    pa_pkg::key_idx_t   alice_key_idx;
    pa_pkg::key_idx_t   bob_key_idx;

    pa_pkg::rand_wr_t   alice_rand_wr;
    pa_pkg::rand_wr_t   bob_rand_wr;
    pa_pkg::rand_addr_t pkt_rand_addr;
    pa_pkg::rand_addr_t alice_eng_rand_addr;
    pa_pkg::rand_addr_t alice_rand_addr;
    pa_pkg::rand_addr_t bob_rand_addr;
    pa_pkg::word_t      alice_rand_data;
    pa_pkg::word_t      bob_rand_data;

    logic               pkt_busy;
    logic               msg_stored;
    logic               msg_accessed;
    logic               rand_ready;
    pa_pkg::msg_wr_t    msg;
    pa_pkg::msg_addr_t  link_rd_addr;
    pa_pkg::word_t      link_rd_data;
    pa_pkg::len_t       bob_len;

    // count switch high cycles up to saturation
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            start_cnt <= '0;
        end else if (start_switch && start_cnt != 8'(pa_pkg::start_sat_cnt)) begin
            start_cnt <= start_cnt + 1'b1;
        end
    end

    assign start_pa = (start_cnt == 8'(pa_pkg::start_fire_cnt));   // single cycle once per reset
    assign load_ok  = (start_cnt < 8'(pa_pkg::start_fire_cnt));    // memories frozen after start

    // shared reconciled key with one read port per side
    always_ff @(posedge clk) begin
        if (load.wr && load.target == pa_pkg::tgt_key && load_ok) begin
            key_mem[load.addr] <= load.data;
        end
        alice_key_q <= key_mem[pa_pkg::key_addr_t'({key_half, alice_key_idx})];
        bob_key_q   <= key_mem[pa_pkg::key_addr_t'({key_half, bob_key_idx})];
    end

    // random target of the load port feeds alice's memory
    assign alice_rand_wr = '{wr:   load.wr && load.target == pa_pkg::tgt_rand && load_ok,
                             addr: pa_pkg::rand_addr_t'(load.addr),
                             data: load.data};

    assign alice_rand_addr = pkt_busy ? pkt_rand_addr : alice_eng_rand_addr;  // packetizer first

    rand_mem u_alice_rand (
        .clk     (clk),
        .wr      (alice_rand_wr),
        .rd_addr (alice_rand_addr),
        .rd_data (alice_rand_data)
    );

    rand_mem u_bob_rand (
        .clk     (clk),
        .wr      (bob_rand_wr),
        .rd_addr (bob_rand_addr),
        .rd_data (bob_rand_data)
    );

    a_packet u_a_packet (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start_pa),
        .secret_len (secret_len),
        .rand_data  (alice_rand_data),
        .rand_addr  (pkt_rand_addr),
        .busy       (pkt_busy),
        .msg        (msg),
        .msg_stored (msg_stored)
    );

    link_model u_link_model (
        .clk          (clk),
        .rst_n        (rst_n),
        .msg          (msg),
        .msg_stored   (msg_stored),
        .rd_addr      (link_rd_addr),
        .rd_data      (link_rd_data),
        .msg_accessed (msg_accessed)
    );

    b_unpacket u_b_unpacket (
        .clk          (clk),
        .rst_n        (rst_n),
        .msg_accessed (msg_accessed),
        .rd_data      (link_rd_data),
        .rd_addr      (link_rd_addr),
        .rand_wr      (bob_rand_wr),
        .secret_len   (bob_len),
        .rand_ready   (rand_ready)
    );

    // alice hashes once her message is out
    pa_engine u_alice_pa (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (msg_stored),
        .secret_len (secret_len),
        .key_data   (alice_key_q),
        .rand_data  (alice_rand_data),
        .key_idx    (alice_key_idx),
        .rand_addr  (alice_eng_rand_addr),
        .secret     (alice_secret),
        .finish     (alice_finish),
        .fail       (alice_fail)
    );

    // bob uses the received length and random bits
    pa_engine u_bob_pa (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (rand_ready),
        .secret_len (bob_len),
        .key_data   (bob_key_q),
        .rand_data  (bob_rand_data),
        .key_idx    (bob_key_idx),
        .rand_addr  (bob_rand_addr),
        .secret     (bob_secret),
        .finish     (bob_finish),
        .fail       (bob_fail)
    );

endmodule

//--- link/b_unpacket.sv
`timescale 1ns/1ps

module b_unpacket (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              msg_accessed,
    input  pa_pkg::word_t     rd_data,
    output pa_pkg::msg_addr_t rd_addr,
    output pa_pkg::rand_wr_t  rand_wr,
    output pa_pkg::len_t      secret_len,
    output logic              rand_ready
);

    logic               run;        // addresses still being issued
    pa_pkg::msg_addr_t  rd_addr_q;
    logic               vld;        // rd_data holds word vld_addr
    pa_pkg::msg_addr_t  vld_addr;
    logic               wr_q;
    pa_pkg::rand_addr_t wr_addr;
    pa_pkg::word_t      wr_data;

    assign rd_addr = rd_addr_q;
    assign rand_wr = '{wr: wr_q, addr: wr_addr, data: wr_data};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            run        <= 1'b0;
            rd_addr_q  <= '0;
            vld        <= 1'b0;
            wr_q       <= 1'b0;
            secret_len <= '0;
            rand_ready <= 1'b0;
        end else begin
            if (msg_accessed && !run) begin
                run       <= 1'b1;
                rd_addr_q <= '0;
            end else if (run) begin
                if (rd_addr_q == pa_pkg::msg_addr_t'(pa_pkg::msg_words - 1)) begin
                    run <= 1'b0;
                end else begin
                    rd_addr_q <= rd_addr_q + 1'b1;
                end
            end
            vld  <= run;
            wr_q <= vld && (vld_addr != '0);   // word 0 is not random data
            if (vld && vld_addr == '0) begin
                secret_len <= pa_pkg::len_t'(rd_data);
            end
            // last random word landed
            rand_ready <= wr_q && (wr_addr == pa_pkg::rand_addr_t'(pa_pkg::rand_words - 1));
        end
    end

    always_ff @(posedge clk) begin
        vld_addr <= rd_addr_q;
        wr_addr  <= pa_pkg::rand_addr_t'(vld_addr - 1'b1);   // message word n to random n-1
        wr_data  <= rd_data;
    end

endmodule

//--- link/link_model.sv
`timescale 1ns/1ps

module link_model (
    input  logic              clk,
    input  logic              rst_n,
    input  pa_pkg::msg_wr_t   msg,
    input  logic              msg_stored,
    input  pa_pkg::msg_addr_t rd_addr,
    output pa_pkg::word_t     rd_data,
    output logic              msg_accessed
);

    pa_pkg::word_t link_buf [pa_pkg::msg_words];
    logic [3:0]    dly;       // cycles left in flight

    // buffer shared by both ends
    always_ff @(posedge clk) begin
        if (msg.wr) begin
            link_buf[msg.addr] <= msg.data;
        end
        rd_data <= link_buf[rd_addr];
    end

    // stored to accessed after link_delay cycles
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dly          <= '0;
            msg_accessed <= 1'b0;
        end else begin
            if (msg_stored) begin
                dly <= 4'(pa_pkg::link_delay - 1);
            end else if (dly != '0) begin
                dly <= dly - 1'b1;
            end
            msg_accessed <= (dly == 4'd1);     // pulse as the counter reaches 0
        end
    end

endmodule

//--- link/a_packet.sv
`timescale 1ns/1ps

module a_packet (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start,
    input  pa_pkg::len_t       secret_len,
    input  pa_pkg::word_t      rand_data,
    output pa_pkg::rand_addr_t rand_addr,
    output logic               busy,
    output pa_pkg::msg_wr_t    msg,
    output logic               msg_stored
);

    pa_pkg::msg_addr_t  step;        // message word written next
    pa_pkg::rand_addr_t rd_addr_q;   // one word ahead of step
    logic               msg_wr;
    pa_pkg::msg_addr_t  msg_addr;
    pa_pkg::word_t      msg_data;

    assign rand_addr = rd_addr_q;
    assign msg       = '{wr: msg_wr, addr: msg_addr, data: msg_data};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            step       <= '0;
            rd_addr_q  <= '0;
            msg_wr     <= 1'b0;
            msg_stored <= 1'b0;
        end else begin
            if (start && !busy) begin
                busy      <= 1'b1;
                step      <= '0;
                rd_addr_q <= '0;               // first read issued during the length word
            end else if (busy) begin
                step <= step + 1'b1;
                if (rd_addr_q != pa_pkg::rand_addr_t'(pa_pkg::rand_words - 1)) begin
                    rd_addr_q <= rd_addr_q + 1'b1;
                end
                if (step == pa_pkg::msg_addr_t'(pa_pkg::msg_words - 1)) begin
                    busy <= 1'b0;              // engine takes the read port
                end
            end
            msg_wr     <= busy;
            msg_stored <= msg_wr && (msg_addr == pa_pkg::msg_addr_t'(pa_pkg::msg_words - 1));
        end
    end

    // word 0 carries the length, then random word step-1
    always_ff @(posedge clk) begin
        msg_addr <= step;
        msg_data <= (step == '0) ? pa_pkg::word_t'(secret_len) : rand_data;
    end

endmodule

//--- pa/pa_engine.sv
`timescale 1ns/1ps

module pa_engine (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start,
    input  pa_pkg::len_t       secret_len,
    input  pa_pkg::word_t      key_data,
    input  pa_pkg::word_t      rand_data,
    output pa_pkg::key_idx_t   key_idx,
    output pa_pkg::rand_addr_t rand_addr,
    output pa_pkg::secret_wr_t secret,
    output logic               finish,
    output logic               fail
);

    pa_pkg::engine_state_t state;
    pa_pkg::secret_addr_t  idx_i;      // secret word being built
    pa_pkg::key_idx_t      idx_k;      // key word being read
    logic                  rd_vld;     // key and random data valid this cycle
    pa_pkg::word_t         acc;
    pa_pkg::word_t         acc_next;
    logic                  len_ok;
    logic                  last_i;
    logic                  sec_wr;
    pa_pkg::secret_addr_t  sec_addr;
    pa_pkg::word_t         sec_data;

    assign len_ok = (secret_len != '0) &&
                    (secret_len <= pa_pkg::len_t'(pa_pkg::max_secret_words));
    assign last_i = (idx_i == pa_pkg::secret_addr_t'(secret_len - 1'b1));

    assign acc_next = rd_vld ? (acc ^ (key_data & rand_data)) : acc;

    // read addresses straight from the counters
    assign key_idx   = idx_k;
    assign rand_addr = pa_pkg::rand_addr_t'(idx_i) + pa_pkg::rand_addr_t'(idx_k);

    assign secret = '{wr: sec_wr, addr: sec_addr, data: sec_data};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= pa_pkg::idle;
            idx_i  <= '0;
            idx_k  <= '0;
            rd_vld <= 1'b0;
            sec_wr <= 1'b0;
            finish <= 1'b0;
            fail   <= 1'b0;
        end else begin
            rd_vld <= (state == pa_pkg::hash);   // data returns a cycle after the read
            sec_wr <= 1'b0;
            case (state)
                pa_pkg::idle: begin
                    if (start) begin
                        state <= pa_pkg::check;
                    end
                end
                pa_pkg::check: begin
                    idx_i <= '0;
                    idx_k <= '0;
                    if (len_ok) begin
                        state <= pa_pkg::hash;
                    end else begin
                        fail  <= 1'b1;             // held until reset
                        state <= pa_pkg::fail;
                    end
                end
                pa_pkg::hash: begin
                    idx_k <= idx_k + 1'b1;         // wraps to 0 for the next word
                    if (idx_k == pa_pkg::key_idx_t'(pa_pkg::key_words - 1)) begin
                        state <= pa_pkg::store;
                    end
                end
                pa_pkg::store: begin
                    sec_wr <= 1'b1;
                    if (last_i) begin
                        state <= pa_pkg::done;
                    end else begin
                        idx_i <= idx_i + 1'b1;
                        state <= pa_pkg::hash;
                    end
                end
                pa_pkg::done: begin
                    finish <= 1'b1;                // a cycle after the last write
                end
                default: begin
                    state <= pa_pkg::fail;         // terminal
                end
            endcase
        end
    end

    // accumulator and write payload
    always_ff @(posedge clk) begin
        if (state == pa_pkg::store) begin
            sec_addr <= idx_i;
            sec_data <= acc_next;                  // includes the last key word
            acc      <= '0;
        end else if (state == pa_pkg::hash) begin
            acc <= acc_next;
        end else begin
            acc <= '0;
        end
    end

endmodule

//--- design/rand_mem.sv
`timescale 1ns/1ps

module rand_mem (
    input  logic               clk,
    input  pa_pkg::rand_wr_t   wr,
    input  pa_pkg::rand_addr_t rd_addr,
    output pa_pkg::word_t      rd_data
);

    pa_pkg::word_t mem [pa_pkg::rand_words];

    always_ff @(posedge clk) begin
        if (wr.wr) begin
            mem[wr.addr] <= wr.data;
        end
        rd_data <= mem[rd_addr];    // one cycle read latency
    end

endmodule

//--- common/pa_pkg.sv
package pa_pkg;

    // data path and memory sizes
    localparam int word_w           = 64;
    localparam int key_words        = 16;                // key words folded into each secret word
    localparam int key_mem_words    = 32;                // two halves of key_words
    localparam int max_secret_words = 8;
    localparam int rand_words       = key_words + max_secret_words;
    localparam int msg_words        = rand_words + 1;    // length word plus random words
    localparam int link_delay       = 8;                 // cycles from stored to accessed

    // start switch debounce
    localparam int start_fire_cnt = 128;
    localparam int start_sat_cnt  = 255;

    // load port target select
    localparam logic tgt_key  = 1'b0;
    localparam logic tgt_rand = 1'b1;

    typedef logic [word_w-1:0]                   word_t;
    typedef logic [$clog2(key_mem_words)-1:0]    key_addr_t;     // half bit + offset
    typedef logic [$clog2(key_words)-1:0]        key_idx_t;
    typedef logic [$clog2(rand_words)-1:0]       rand_addr_t;
    typedef logic [$clog2(msg_words)-1:0]        msg_addr_t;
    typedef logic [$clog2(max_secret_words)-1:0] secret_addr_t;
    typedef logic [31:0]                         len_t;          // length in words

    typedef struct packed {
        logic      wr;
        logic      target;     // tgt_key or tgt_rand
        key_addr_t addr;
        word_t     data;
    } load_wr_t;

    typedef struct packed {
        logic       wr;
        rand_addr_t addr;
        word_t      data;
    } rand_wr_t;

    typedef struct packed {
        logic         wr;
        secret_addr_t addr;
        word_t        data;
    } secret_wr_t;

    typedef struct packed {
        logic      wr;
        msg_addr_t addr;
        word_t     data;
    } msg_wr_t;

    typedef enum logic [2:0] {idle, check, hash, store, done, fail} engine_state_t;

endpackage
